//--- apb_vertex_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_vertex_port (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire [tri_pkg::ADDR_W-1:0]  paddr,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [tri_pkg::VERT_W-1:0]  pwdata,
  output logic [tri_pkg::VERT_W-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  wire                        full,
  input  wire [tri_pkg::LEVEL_W-1:0] level,
  input  wire                        setup_valid,
  input  wire                        flush,
  output logic                       push,
  output logic [tri_pkg::VERT_W-1:0] push_data
);

  typedef logic [tri_pkg::CNT_W-1:0] cnt_t;

  logic access;
  logic is_vertex;
  logic addr_ok;
  cnt_t tri_count;
  cnt_t flush_count;

  assign access    = psel && penable;
  assign is_vertex = (paddr == tri_pkg::REG_VERTEX);

  // Vertex writes wait while the FIFO is full
  assign pready  = access && !(pwrite && is_vertex && full);
  assign pslverr = pready && !addr_ok;

  assign push      = pready && pwrite && is_vertex;
  assign push_data = pwdata;

  //////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////

  always_comb
  begin
    addr_ok = !pwrite;
    prdata  = '0;
    case (paddr)
      tri_pkg::REG_VERTEX:
      begin
        addr_ok = 1'b1;
      end
      tri_pkg::REG_STATUS:
      begin
        prdata[tri_pkg::LEVEL_W-1:0] = level;
        prdata[tri_pkg::FULL_BIT]    = full;
      end
      tri_pkg::REG_TRI_COUNT:
      begin
        prdata[tri_pkg::CNT_W-1:0] = tri_count;
      end
      tri_pkg::REG_FLUSH_COUNT:
      begin
        prdata[tri_pkg::CNT_W-1:0] = flush_count;
      end
      default:
      begin
        addr_ok = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Event counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tri_count   <= '0;
      flush_count <= '0;
    end
    else
    begin
      if (setup_valid)
      begin
        tri_count <= tri_count + cnt_t'(1);
      end
      if (flush)
      begin
        flush_count <= flush_count + cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
tri_pkg.sv
apb_vertex_port.sv
vertex_fifo.sv
triangle_setup.sv
setup_top.sv
setup_props.sv
tb_setup.sv

//--- run.sh
#!/bin/sh
# Build and run the triangle setup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_setup \
  -f filelist.f -o tb_setup_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_setup_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in sim.log"
exit 1

//--- setup_props.sv
`timescale 1ns/1ps
`default_nettype none

module setup_props (
  input wire clk,
  input wire arst_n,
  input wire setup_valid,
  input wire flush,
  input wire push,
  input wire full,
  input wire psel,
  input wire penable,
  input wire pready,
  input wire pslverr
);

  //////////////////////////////////////////////////
  // Output strobes
  //////////////////////////////////////////////////

  a_valid_flush_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(setup_valid && flush))
    else $error("setup_valid and flush high in the same cycle");

  //////////////////////////////////////////////////
  // FIFO and bus
  //////////////////////////////////////////////////

  a_push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> !full)
    else $error("push while the vertex FIFO is full");

  a_pslverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> (psel && penable && pready))
    else $error("pslverr outside a completing access phase");

endmodule

bind setup_top setup_props u_props (
  .clk         (clk),
  .arst_n      (arst_n),
  .setup_valid (setup_valid),
  .flush       (flush),
  .push        (push),
  .full        (full),
  .psel        (psel),
  .penable     (penable),
  .pready      (pready),
  .pslverr     (pslverr)
);

`default_nettype wire

//--- setup_top.sv
`timescale 1ns/1ps
`default_nettype none

module setup_top (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire        [tri_pkg::ADDR_W-1:0]  paddr,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire        [tri_pkg::VERT_W-1:0]  pwdata,
  output wire        [tri_pkg::VERT_W-1:0]  prdata,
  output wire                               pready,
  output wire                               pslverr,
  output wire                               setup_valid,
  output wire                               flush,
  output wire signed [tri_pkg::DELTA_W-1:0] dx12,
  output wire signed [tri_pkg::DELTA_W-1:0] dx23,
  output wire signed [tri_pkg::DELTA_W-1:0] dx31,
  output wire signed [tri_pkg::DELTA_W-1:0] dy12,
  output wire signed [tri_pkg::DELTA_W-1:0] dy23,
  output wire signed [tri_pkg::DELTA_W-1:0] dy31,
  output wire signed [tri_pkg::COORD_W-1:0] min_x,
  output wire signed [tri_pkg::COORD_W-1:0] max_x,
  output wire signed [tri_pkg::COORD_W-1:0] min_y,
  output wire signed [tri_pkg::COORD_W-1:0] max_y,
  output wire signed [tri_pkg::RES_W-1:0]   alpha,
  output wire signed [tri_pkg::RES_W-1:0]   beta,
  output wire signed [tri_pkg::RES_W-1:0]   gamma,
  output wire signed [tri_pkg::RES_W-1:0]   cy1,
  output wire signed [tri_pkg::RES_W-1:0]   cy2,
  output wire signed [tri_pkg::RES_W-1:0]   cy3
);

  wire                        push;
  wire [tri_pkg::VERT_W-1:0]  push_data;
  wire                        full;
  wire [tri_pkg::LEVEL_W-1:0] level;
  wire                        pop;
  wire                        empty;
  wire [tri_pkg::VERT_W-1:0]  head;

  apb_vertex_port u_port (
    .clk         (clk),
    .arst_n      (arst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .full        (full),
    .level       (level),
    .setup_valid (setup_valid),
    .flush       (flush),
    .push        (push),
    .push_data   (push_data)
  );

  vertex_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full),
    .level     (level)
  );

  triangle_setup u_setup (
    .clk         (clk),
    .arst_n      (arst_n),
    .empty       (empty),
    .head        (head),
    .pop         (pop),
    .setup_valid (setup_valid),
    .flush       (flush),
    .dx12        (dx12),
    .dx23        (dx23),
    .dx31        (dx31),
    .dy12        (dy12),
    .dy23        (dy23),
    .dy31        (dy31),
    .min_x       (min_x),
    .max_x       (max_x),
    .min_y       (min_y),
    .max_y       (max_y),
    .alpha       (alpha),
    .beta        (beta),
    .gamma       (gamma),
    .cy1         (cy1),
    .cy2         (cy2),
    .cy3         (cy3)
  );

endmodule

`default_nettype wire

//--- tb_setup.sv
`timescale 1ns/1ps
`default_nettype none

module tb_setup;

  localparam int NUM_DIRECTED   = 6;
  localparam int NUM_ROWS       = 24;
  localparam int BURST_ROWS     = 4;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 300;

  logic clk = 1'b0;
  logic arst_n;
  logic [tri_pkg::ADDR_W-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [tri_pkg::VERT_W-1:0] pwdata;
  wire  [tri_pkg::VERT_W-1:0] prdata;
  wire  pready;
  wire  pslverr;
  wire  setup_valid;
  wire  flush;
  wire signed [tri_pkg::DELTA_W-1:0] dx12, dx23, dx31, dy12, dy23, dy31;
  wire signed [tri_pkg::COORD_W-1:0] min_x, max_x, min_y, max_y;
  wire signed [tri_pkg::RES_W-1:0]   alpha, beta, gamma, cy1, cy2, cy3;

  // Stimulus table with one triangle per row
  logic [31:0] vtx_a [NUM_ROWS];
  logic [31:0] vtx_b [NUM_ROWS];
  logic [31:0] vtx_c [NUM_ROWS];
  logic        exp_flush [NUM_ROWS];
  int          box_min_x [NUM_ROWS];
  int          box_max_x [NUM_ROWS];
  int          box_min_y [NUM_ROWS];
  int          box_max_y [NUM_ROWS];

  string field_name [12] = '{"dx12", "dx23", "dx31", "dy12", "dy23", "dy31",
                             "alpha", "beta", "gamma", "cy1", "cy2", "cy3"};

  int pending [$];
  int seen_rows       = 0;
  int exp_tris        = 0;
  int exp_flushes     = 0;
  int pushes          = 0;
  int value_errors    = 0;
  int protocol_errors = 0;
  int timeouts        = 0;
  int cycles          = 0;
  logic [31:0] lfsr_state = 32'h4867d3a9;

  setup_top UUT (
    .clk (clk), .arst_n (arst_n),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .setup_valid (setup_valid), .flush (flush),
    .dx12 (dx12), .dx23 (dx23), .dx31 (dx31), .dy12 (dy12), .dy23 (dy23), .dy31 (dy31),
    .min_x (min_x), .max_x (max_x), .min_y (min_y), .max_y (max_y),
    .alpha (alpha), .beta (beta), .gamma (gamma), .cy1 (cy1), .cy2 (cy2), .cy3 (cy3)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic logic [31:0] vtx(input int x, input int y);
    return {x[15:0], y[15:0]};
  endfunction

  // Expected edge values straight from the setup equations
  function automatic longint ref_value(input int row, input int field);
    longint x1, y1, x2, y2, x3, y3;
    longint ex12, ex23, ex31, ey12, ey23, ey31;
    x1 = longint'($signed(vtx_a[row][31:16]));
    y1 = longint'($signed(vtx_a[row][15:0]));
    x2 = longint'($signed(vtx_b[row][31:16]));
    y2 = longint'($signed(vtx_b[row][15:0]));
    x3 = longint'($signed(vtx_c[row][31:16]));
    y3 = longint'($signed(vtx_c[row][15:0]));
    ex12 = x1 - x2;
    ex23 = x2 - x3;
    ex31 = x3 - x1;
    ey12 = y1 - y2;
    ey23 = y2 - y3;
    ey31 = y3 - y1;
    case (field)
      0:       return ex12;
      1:       return ex23;
      2:       return ex31;
      3:       return ey12;
      4:       return ey23;
      5:       return ey31;
      6:       return ey12 * ex23 - ey23 * ex12;
      7:       return ey23 * ex31 - ey31 * ex23;
      8:       return ey31 * ex12 - ey12 * ex31;
      9:       return ey12 * (x1 - box_min_x[row]) + ex12 * (box_min_y[row] - y1);
      10:      return ey23 * (x2 - box_min_x[row]) + ex23 * (box_min_y[row] - y2);
      default: return ey31 * (x3 - box_min_x[row]) + ex31 * (box_min_y[row] - y3);
    endcase
  endfunction

  task automatic set_row(input int r, input logic [31:0] a, b, c, input logic fl,
                         input int mnx, mxx, mny, mxy);
    vtx_a[r]     = a;
    vtx_b[r]     = b;
    vtx_c[r]     = c;
    exp_flush[r] = fl;
    box_min_x[r] = mnx;
    box_max_x[r] = mxx;
    box_min_y[r] = mny;
    box_max_y[r] = mxy;
  endtask

  task automatic fill_table();
    int xs [3];
    int ys [3];
    set_row(0, vtx(10, 20), vtx(30, 5), vtx(-4, 12), 1'b0, -4, 30, 5, 20);
    // Degenerate triangle with collinear vertices
    set_row(1, vtx(0, 0), vtx(5, 5), vtx(10, 10), 1'b0, 0, 10, 0, 10);
    set_row(2, vtx(-100, -200), vtx(-50, -300), vtx(-150, -250), 1'b0,
            -150, -50, -300, -200);
    set_row(3, tri_pkg::FLUSH_MARKER, vtx(1, 2), vtx(3, 4), 1'b1, 0, 0, 0, 0);
    set_row(4, vtx(32767, -32768), vtx(-32768, 32767), vtx(0, 0), 1'b0,
            -32768, 32767, -32768, 32767);
    set_row(5, vtx(7, -7), vtx(7, -7), vtx(7, -7), 1'b0, 7, 7, -7, -7);
    for (int r = NUM_DIRECTED; r < NUM_ROWS; r++)
    begin
      vtx_a[r] = take_bits(32);
      vtx_b[r] = take_bits(32);
      vtx_c[r] = take_bits(32);
      if (take_bits(3) == 0)
        vtx_a[r] = tri_pkg::FLUSH_MARKER;
      exp_flush[r] = (vtx_a[r] == tri_pkg::FLUSH_MARKER);
      xs = '{int'($signed(vtx_a[r][31:16])), int'($signed(vtx_b[r][31:16])),
             int'($signed(vtx_c[r][31:16]))};
      ys = '{int'($signed(vtx_a[r][15:0])), int'($signed(vtx_b[r][15:0])),
             int'($signed(vtx_c[r][15:0]))};
      box_min_x[r] = xs[0];
      box_max_x[r] = xs[0];
      box_min_y[r] = ys[0];
      box_max_y[r] = ys[0];
      for (int k = 1; k < 3; k++)
      begin
        if (xs[k] < box_min_x[r]) box_min_x[r] = xs[k];
        if (xs[k] > box_max_x[r]) box_max_x[r] = xs[k];
        if (ys[k] < box_min_y[r]) box_min_y[r] = ys[k];
        if (ys[k] > box_max_y[r]) box_max_y[r] = ys[k];
      end
    end
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      pending.push_back(r);
      if (exp_flush[r])
        exp_flushes++;
      else
        exp_tris++;
    end
  endtask

  task automatic report_value(input int row, input string name, input longint got, exp);
    value_errors++;
    $display("Error at %0t: row %0d %s is %0d, expected %0d", $time, row, name, got, exp);
  endtask

  task automatic check_row(input int row);
    longint got [12];
    got = '{longint'(dx12), longint'(dx23), longint'(dx31), longint'(dy12),
            longint'(dy23), longint'(dy31), longint'(alpha), longint'(beta),
            longint'(gamma), longint'(cy1), longint'(cy2), longint'(cy3)};
    if (int'(min_x) != box_min_x[row]) report_value(row, "min_x", min_x, box_min_x[row]);
    if (int'(max_x) != box_max_x[row]) report_value(row, "max_x", max_x, box_max_x[row]);
    if (int'(min_y) != box_min_y[row]) report_value(row, "min_y", min_y, box_min_y[row]);
    if (int'(max_y) != box_max_y[row]) report_value(row, "max_y", max_y, box_max_y[row]);
    for (int f = 0; f < 12; f++)
    begin
      if (got[f] != ref_value(row, f))
        report_value(row, field_name[f], got[f], ref_value(row, f));
    end
  endtask

  // Starts at 1 ns after a rising edge and returns at the same phase
  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    logic done;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done  = pready;
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_vertex(input logic [31:0] word);
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b1, tri_pkg::REG_VERTEX, word, rdata, err);
    if (err)
    begin
      protocol_errors++;
      $display("A vertex write at %0t was answered with pslverr", $time);
    end
  endtask

  task automatic check_reg(input logic [7:0] addr, input string name, input longint exp);
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b0, addr, '0, rdata, err);
    if (err || longint'(rdata) != exp)
      report_value(-1, name, longint'(rdata), exp);
  endtask

  task automatic finish_run();
    $display("Summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Monitors and watchdog
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    int row;
    if (arst_n && UUT.push)
    begin
      pushes++;
    end
    if (arst_n && psel && penable && !pready && !UUT.full)
    begin
      protocol_errors++;
      $display("pready was held low at %0t although the FIFO was not full", $time);
    end
    if (arst_n && (setup_valid || flush))
    begin
      if (pending.size() == 0)
      begin
        protocol_errors++;
        $display("A result appeared at %0t with no triangle outstanding", $time);
      end
      else
      begin
        row = pending.pop_front();
        seen_rows++;
        if (flush != exp_flush[row])
        begin
          protocol_errors++;
          $display("Row %0d gave a %s instead of a %s", row, flush ? "flush" : "result",
                   exp_flush[row] ? "flush" : "result");
        end
        else if (setup_valid)
          check_row(row);
      end
    end
  end

  // Handshake rules on the strobes, push and pslverr
  always @(negedge clk)
  begin
    if (arst_n && ((setup_valid && flush) || (UUT.push && UUT.full) ||
                   (pslverr && !(psel && penable && pready))))
    begin
      protocol_errors++;
      $display("Handshake rule broken at %0t: valid=%0b flush=%0b push=%0b full=%0b pslverr=%0b",
               $time, setup_valid, flush, UUT.push, UUT.full, pslverr);
      finish_run();
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES)
    begin
      timeouts++;
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rdata;
    logic err;
    int gap;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    fill_table();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    if (setup_valid || flush)
    begin
      protocol_errors++;
      $display("Result strobes were not low after reset");
    end
    check_reg(tri_pkg::REG_TRI_COUNT, "tri count after reset", 0);
    check_reg(tri_pkg::REG_FLUSH_COUNT, "flush count after reset", 0);

    // The last rows go out back to back
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      write_vertex(vtx_a[r]);
      write_vertex(vtx_b[r]);
      write_vertex(vtx_c[r]);
      if (r < NUM_ROWS - BURST_ROWS)
      begin
        gap = take_bits(2);
        repeat (gap)
        begin
          @(posedge clk);
          #1;
        end
      end
    end

    while (seen_rows < NUM_ROWS)
    begin
      @(posedge clk);
      #1;
    end

    check_reg(tri_pkg::REG_STATUS, "status after drain", 0);
    check_reg(tri_pkg::REG_TRI_COUNT, "tri count", exp_tris);
    check_reg(tri_pkg::REG_FLUSH_COUNT, "flush count", exp_flushes);

    // Bad accesses must error and leave the state alone
    apb_transfer(1'b1, tri_pkg::REG_STATUS, 32'h0000_0005, rdata, err);
    if (!err)
      report_value(-1, "pslverr on status write", err, 1);
    apb_transfer(1'b0, 8'h10, '0, rdata, err);
    if (!err)
      report_value(-1, "pslverr on offset 0x10 read", err, 1);
    // Three vertex words per row and nothing else reaches the FIFO
    if (pushes != 3 * NUM_ROWS)
      report_value(-1, "vertex pushes", pushes, 3 * NUM_ROWS);
    check_reg(tri_pkg::REG_STATUS, "status after bad accesses", 0);
    check_reg(tri_pkg::REG_TRI_COUNT, "tri count after bad accesses", exp_tris);
    check_reg(tri_pkg::REG_FLUSH_COUNT, "flush count after bad accesses", exp_flushes);

    finish_run();
  end

endmodule

`default_nettype wire

//--- tri_pkg.sv
`default_nettype none

package tri_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int COORD_W = 16;
  localparam int VERT_W  = 32;
  localparam int DELTA_W = 17;
  localparam int PROD_W  = 2 * DELTA_W;
  localparam int RES_W   = 36;
  localparam int CNT_W   = 16;
  localparam int ADDR_W  = 8;

  // Vertex FIFO geometry
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W    = 4;

  // Status register layout with the level in the low bits
  localparam int FULL_BIT = 8;

  // First vertex of a flush triangle
  localparam logic [VERT_W-1:0] FLUSH_MARKER = '1;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [ADDR_W-1:0] {
    REG_VERTEX      = 'h0,
    REG_STATUS      = 'h4,
    REG_TRI_COUNT   = 'h8,
    REG_FLUSH_COUNT = 'hC
  } reg_offset_e;

  typedef enum logic [1:0] {
    G_V1,
    G_V2,
    G_V3
  } gather_state_e;

endpackage

`default_nettype wire

//--- triangle_setup.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_setup (
  input  wire                                clk,
  input  wire                                arst_n,
  input  wire                                empty,
  input  wire        [tri_pkg::VERT_W-1:0]   head,
  output logic                               pop,
  output logic                               setup_valid,
  output logic                               flush,
  output logic signed [tri_pkg::DELTA_W-1:0] dx12,
  output logic signed [tri_pkg::DELTA_W-1:0] dx23,
  output logic signed [tri_pkg::DELTA_W-1:0] dx31,
  output logic signed [tri_pkg::DELTA_W-1:0] dy12,
  output logic signed [tri_pkg::DELTA_W-1:0] dy23,
  output logic signed [tri_pkg::DELTA_W-1:0] dy31,
  output logic signed [tri_pkg::COORD_W-1:0] min_x,
  output logic signed [tri_pkg::COORD_W-1:0] max_x,
  output logic signed [tri_pkg::COORD_W-1:0] min_y,
  output logic signed [tri_pkg::COORD_W-1:0] max_y,
  output logic signed [tri_pkg::RES_W-1:0]   alpha,
  output logic signed [tri_pkg::RES_W-1:0]   beta,
  output logic signed [tri_pkg::RES_W-1:0]   gamma,
  output logic signed [tri_pkg::RES_W-1:0]   cy1,
  output logic signed [tri_pkg::RES_W-1:0]   cy2,
  output logic signed [tri_pkg::RES_W-1:0]   cy3
);

  typedef logic signed [tri_pkg::COORD_W-1:0] coord_t;
  typedef logic signed [tri_pkg::DELTA_W-1:0] delta_t;
  typedef logic signed [tri_pkg::PROD_W-1:0]  prod_t;

  tri_pkg::gather_state_e state;
  logic [tri_pkg::VERT_W-1:0] v1, v2, v3;
  logic launch;

  coord_t x1, y1, x2, y2, x3, y3;
  coord_t min_x_c, max_x_c, min_y_c, max_y_c;

  logic   s1_valid;
  delta_t s1_dx12, s1_dx23, s1_dx31, s1_dy12, s1_dy23, s1_dy31;
  coord_t s1_min_x, s1_max_x, s1_min_y, s1_max_y;
  delta_t s1_ox1, s1_ox2, s1_ox3, s1_oy1, s1_oy2, s1_oy3;

  logic   s2_valid;
  delta_t s2_dx12, s2_dx23, s2_dx31, s2_dy12, s2_dy23, s2_dy31;
  coord_t s2_min_x, s2_max_x, s2_min_y, s2_max_y;
  prod_t  s2_a1, s2_a2, s2_b1, s2_b2, s2_g1, s2_g2;
  prod_t  s2_c1a, s2_c1b, s2_c2a, s2_c2b, s2_c3a, s2_c3b;

  // One word per cycle whenever the FIFO has one
  assign pop = !empty;

  //////////////////////////////////////////////////
  // Vertex gather
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state  <= tri_pkg::G_V1;
      launch <= 1'b0;
      flush  <= 1'b0;
    end
    else
    begin
      launch <= 1'b0;
      flush  <= 1'b0;
      if (pop)
      begin
        case (state)
          tri_pkg::G_V1: state <= tri_pkg::G_V2;
          tri_pkg::G_V2: state <= tri_pkg::G_V3;
          default:
          begin
            state  <= tri_pkg::G_V1;
            flush  <= (v1 == tri_pkg::FLUSH_MARKER);
            launch <= (v1 != tri_pkg::FLUSH_MARKER);
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      case (state)
        tri_pkg::G_V1: v1 <= head;
        tri_pkg::G_V2: v2 <= head;
        default:       v3 <= head;
      endcase
    end
  end

  // x in the upper half, y in the lower half
  assign x1 = v1[tri_pkg::VERT_W-1 -: tri_pkg::COORD_W];
  assign y1 = v1[tri_pkg::COORD_W-1:0];
  assign x2 = v2[tri_pkg::VERT_W-1 -: tri_pkg::COORD_W];
  assign y2 = v2[tri_pkg::COORD_W-1:0];
  assign x3 = v3[tri_pkg::VERT_W-1 -: tri_pkg::COORD_W];
  assign y3 = v3[tri_pkg::COORD_W-1:0];

  // Bounding box
  assign min_x_c = (x1 < x2) ? ((x1 < x3) ? x1 : x3) : ((x2 < x3) ? x2 : x3);
  assign max_x_c = (x1 > x2) ? ((x1 > x3) ? x1 : x3) : ((x2 > x3) ? x2 : x3);
  assign min_y_c = (y1 < y2) ? ((y1 < y3) ? y1 : y3) : ((y2 < y3) ? y2 : y3);
  assign max_y_c = (y1 > y2) ? ((y1 > y3) ? y1 : y3) : ((y2 > y3) ? y2 : y3);

  //////////////////////////////////////////////////
  // Valid pipe
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      setup_valid <= 1'b0;
    end
    else
    begin
      s1_valid    <= launch;
      s2_valid    <= s1_valid;
      setup_valid <= s2_valid;
    end
  end

  //////////////////////////////////////////////////
  // Arithmetic stages
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // Stage 1 deltas, box and corner offsets
    s1_dx12  <= x1 - x2;
    s1_dx23  <= x2 - x3;
    s1_dx31  <= x3 - x1;
    s1_dy12  <= y1 - y2;
    s1_dy23  <= y2 - y3;
    s1_dy31  <= y3 - y1;
    s1_min_x <= min_x_c;
    s1_max_x <= max_x_c;
    s1_min_y <= min_y_c;
    s1_max_y <= max_y_c;
    s1_ox1   <= x1 - min_x_c;
    s1_ox2   <= x2 - min_x_c;
    s1_ox3   <= x3 - min_x_c;
    s1_oy1   <= min_y_c - y1;
    s1_oy2   <= min_y_c - y2;
    s1_oy3   <= min_y_c - y3;

    // Stage 2 products
    s2_a1  <= s1_dy12 * s1_dx23;
    s2_a2  <= s1_dy23 * s1_dx12;
    s2_b1  <= s1_dy23 * s1_dx31;
    s2_b2  <= s1_dy31 * s1_dx23;
    s2_g1  <= s1_dy31 * s1_dx12;
    s2_g2  <= s1_dy12 * s1_dx31;
    s2_c1a <= s1_dy12 * s1_ox1;
    s2_c1b <= s1_dx12 * s1_oy1;
    s2_c2a <= s1_dy23 * s1_ox2;
    s2_c2b <= s1_dx23 * s1_oy2;
    s2_c3a <= s1_dy31 * s1_ox3;
    s2_c3b <= s1_dx31 * s1_oy3;
    s2_dx12  <= s1_dx12;
    s2_dx23  <= s1_dx23;
    s2_dx31  <= s1_dx31;
    s2_dy12  <= s1_dy12;
    s2_dy23  <= s1_dy23;
    s2_dy31  <= s1_dy31;
    s2_min_x <= s1_min_x;
    s2_max_x <= s1_max_x;
    s2_min_y <= s1_min_y;
    s2_max_y <= s1_max_y;

    // Stage 3 edge constants and initial values
    alpha <= s2_a1 - s2_a2;
    beta  <= s2_b1 - s2_b2;
    gamma <= s2_g1 - s2_g2;
    cy1   <= s2_c1a + s2_c1b;
    cy2   <= s2_c2a + s2_c2b;
    cy3   <= s2_c3a + s2_c3b;
    dx12  <= s2_dx12;
    dx23  <= s2_dx23;
    dx31  <= s2_dx31;
    dy12  <= s2_dy12;
    dy23  <= s2_dy23;
    dy31  <= s2_dy31;
    min_x <= s2_min_x;
    max_x <= s2_max_x;
    min_y <= s2_min_y;
    max_y <= s2_max_y;
  end

endmodule

`default_nettype wire

//--- vertex_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_fifo (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         push,
  input  wire  [tri_pkg::VERT_W-1:0]  push_data,
  input  wire                         pop,
  output logic [tri_pkg::VERT_W-1:0]  head,
  output logic                        empty,
  output logic                        full,
  output logic [tri_pkg::LEVEL_W-1:0] level
);

  typedef logic [tri_pkg::PTR_W-1:0]   ptr_t;
  typedef logic [tri_pkg::LEVEL_W-1:0] level_t;

  logic [tri_pkg::VERT_W-1:0] mem [tri_pkg::FIFO_DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (level == level_t'(0));
  assign full  = (level == level_t'(tri_pkg::FIFO_DEPTH));

  // Show-ahead head always holds the oldest word
  assign head = mem[rd_ptr];

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + level_t'(1);
        2'b01:   level <= level - level_t'(1);
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire
